// File: filelist.f
pi1_pkg.sv
rst_ctrl.sv
pi1_router.sv
scratch_ram.sv
devtbl.sv
intctrl.sv
soc_top.sv
tb_soc_top.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; a $fatal gives a nonzero status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_top -f filelist.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build returned status $status"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit $status
fi

exit 0

// File: tb_soc_top.sv
/* random traffic from a fixed seed, checked against a model in the testbench; RAM
   traffic stays in 64 words spread over the RAM so every read hits a known word */
`timescale 1ns/1ps

module tb_soc_top;
	import pi1_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RAM_TEST_N = 64;
	localparam int RAM_OPS    = 300;
	localparam int DFLT_OPS   = 20;
	localparam int INT_ITER   = 40;
	localparam int BUS_LIMIT  = 50;
	localparam int TXN_N      = RAM_TEST_N + RAM_OPS + 2 * DFLT_OPS + 5 * INT_ITER + 40;
	localparam int RST_TIME   = 10 * (RST_CYCLES + 10);
	localparam logic [PI1_ADDR_W-1:0] DEV_BASE = SLV_BASE[SLV_DEV];
	localparam logic [PI1_ADDR_W-1:0] INT_BASE = SLV_BASE[SLV_INT];
	localparam logic [PI1_ADDR_W-1:0] MAP_END  = SLV_BASE[SLV_INT] + SLV_SIZE[SLV_INT];
	// byte sizes of RAM, device table and interrupt controller
	localparam logic [PI1_DATA_W-1:0] REGION_BYTES [SLV_N] = '{32'h1000, 32'h100, 32'h100};

	logic                  clk_w;
	logic                  rst_p;
	pi1_req_t              req;
	pi1_rsp_t              rsp;
	logic [INT_SRC_N-1:0]  int_src;
	logic                  irq;
	logic [INT_SRC_N-1:0]  int_ack;
	logic                  sys_rst;
	logic [PI1_DATA_W-1:0] ram_model [RAM_TEST_N];
	logic [INT_SRC_N-1:0]  en_model;
	logic [INT_SRC_N-1:0]  pend_model;
	logic [INT_SRC_N-1:0]  src_model;

	soc_top i_dut (
		.clk_w     (clk_w),
		.rst_p     (rst_p),
		.req_i     (req),
		.rsp_o     (rsp),
		.int_src_i (int_src),
		.irq_o     (irq),
		.int_ack_o (int_ack),
		.sys_rst_o (sys_rst)
	);

	initial clk_w = 1'b0;
	always #(CLK_PERIOD / 2) clk_w = ~clk_w;

	// #################### checks
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "%s", msg);
	endtask

	task automatic compare_rsp(input string name, input pi1_rsp_t got, input pi1_rsp_t exp);
		if (got !== exp)
			stop_run($sformatf("mismatch rsp_o %s: got data %h rdy %h, expected data %h rdy %h",
				name, got.data, got.rdy, exp.data, exp.rdy));
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic compare_ack(input logic [INT_SRC_N-1:0] got, input logic [INT_SRC_N-1:0] exp);
		if (got !== exp)
			stop_run($sformatf("mismatch int_ack_o: got %h, expected %h", got, exp));
	endtask

	// #################### bus and model helpers
	task automatic bus_xfer(input pi1_op_t op, input logic [PI1_ADDR_W-1:0] addr,
			input logic [PI1_DATA_W-1:0] wdata, input logic [PI1_SEL_W-1:0] sel,
			output pi1_rsp_t got);
		int lat;
		int exp_lat;
		lat     = 0;
		exp_lat = (addr < MAP_END) ? 1 : 0; // mapped slaves answer one cycle late
		@(posedge clk_w);
		#1;
		req.op   = op;
		req.addr = addr;
		req.data = wdata;
		req.sel  = sel;
		@(negedge clk_w);
		while (!rsp.rdy) begin
			lat++;
			if (lat > BUS_LIMIT)
				stop_run($sformatf("request to word %h never got rdy", addr));
			@(negedge clk_w);
		end
		got = rsp;
		if (lat != exp_lat)
			stop_run($sformatf("mismatch rdy latency at word %h: got %h, expected %h",
				addr, lat, exp_lat));
		@(posedge clk_w);
		#1;
		req.op = OP_NOP;
	endtask

	task automatic read_check(input logic [PI1_ADDR_W-1:0] addr,
			input logic [PI1_DATA_W-1:0] exp_data, input string name);
		pi1_rsp_t got;
		pi1_rsp_t exp;
		exp.data = exp_data;
		exp.rdy  = 1'b1;
		bus_xfer(OP_RD, addr, '0, '0, got);
		compare_rsp(name, got, exp);
	endtask

	// test words spread over the whole RAM with varying low bits
	function automatic logic [PI1_ADDR_W-1:0] ram_addr(input int k);
		return PI1_ADDR_W'(k * 16 + k % 16);
	endfunction

	function automatic logic [PI1_DATA_W-1:0] merge_bytes(input logic [PI1_DATA_W-1:0] old_w,
			input logic [PI1_DATA_W-1:0] new_w, input logic [PI1_SEL_W-1:0] sel);
		logic [PI1_DATA_W-1:0] res;
		res = old_w;
		for (int b = 0; b < PI1_SEL_W; b++) begin
			if (sel[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

	function automatic logic [PI1_DATA_W-1:0] first_pending(input logic [INT_SRC_N-1:0] act);
		for (int i = 0; i < INT_SRC_N; i++) begin
			if (act[i])
				return PI1_DATA_W'(i);
		end
		return INT_NONE;
	endfunction

	// counts the cycles of a reset hold, starting at the next falling edge
	task automatic check_hold();
		int n;
		n = 0;
		@(negedge clk_w);
		while (sys_rst) begin
			n++;
			if (n > RST_CYCLES)
				stop_run("sys_rst_o stayed high past the reset count");
			compare_bit("rsp_o.rdy", rsp.rdy, 1'b0);
			compare_ack(int_ack, '0);
			@(negedge clk_w);
		end
		if (n != RST_CYCLES)
			stop_run($sformatf("mismatch sys_rst_o hold: got %h cycles, expected %h", n, RST_CYCLES));
		en_model   = '0;
		pend_model = '0;
		compare_bit("irq_o", irq, 1'b0);
	endtask

	task automatic check_ram_words(input int count);
		for (int i = 0; i < count; i++)
			read_check(ram_addr(i * 7 % RAM_TEST_N), ram_model[i * 7 % RAM_TEST_N], "ram word");
	endtask

	initial begin
		#(CLK_PERIOD * (200 * TXN_N + RST_TIME));
		stop_run("watchdog expired before the tests finished");
	end

	// #################### test sequence
	initial begin
		pi1_rsp_t              got;
		logic [PI1_DATA_W-1:0] d;
		logic [PI1_DATA_W-1:0] exp_idx;
		logic [PI1_SEL_W-1:0]  sel;
		logic [PI1_ADDR_W-1:0] a;
		logic [INT_SRC_N-1:0]  src_new;
		pi1_op_t               op;
		int                    k;
		rst_p      = 1'b1;
		req        = '0;
		int_src    = '0;
		en_model   = '0;
		pend_model = '0;
		src_model  = '0;
		void'($urandom(32'hef807bc8));
		repeat (10) @(posedge clk_w);
		#1;
		rst_p = 1'b0;
		check_hold();

		for (int i = 0; i < RAM_TEST_N; i++) begin
			ram_model[i] = $urandom;
			bus_xfer(OP_WR, ram_addr(i), ram_model[i], 4'hf, got);
		end
		for (int i = 0; i < RAM_OPS; i++) begin
			k   = $urandom % RAM_TEST_N;
			op  = pi1_op_t'(1 + $urandom % 3); // RD, WR or RW
			d   = $urandom;
			sel = PI1_SEL_W'($urandom);
			bus_xfer(op, ram_addr(k), d, sel, got);
			if (op != OP_WR)
				compare_rsp("ram old word", got, '{data: ram_model[k], rdy: 1'b1});
			if (op != OP_RD)
				ram_model[k] = merge_bytes(ram_model[k], d, sel);
		end

		for (int i = 0; i < SLV_N; i++)
			read_check(DEV_BASE + PI1_ADDR_W'(i), REGION_BYTES[i], "region size");
		read_check(DEV_BASE + PI1_ADDR_W'(5), '0, "unused device word");
		read_check(DEV_BASE + PI1_ADDR_W'(DEVTBL_RST_IDX), '0, "reset command");
		for (int i = 0; i < DFLT_OPS; i++) begin
			a = MAP_END + PI1_ADDR_W'({$urandom} % (32'h4000_0000 - {2'b00, MAP_END}));
			bus_xfer(OP_WR, a, $urandom, 4'hf, got);
			read_check(a, '0, "default slave");
		end
		check_ram_words(8);

		for (int i = 0; i < INT_ITER; i++) begin
			src_new = INT_SRC_N'($urandom);
			@(posedge clk_w);
			#1;
			int_src     = src_new;
			pend_model |= src_new & ~src_model;
			src_model   = src_new;
			@(negedge clk_w);
			@(negedge clk_w); // the edge in between has latched the sources
			compare_bit("irq_o", irq, |(pend_model & en_model));
			if ($urandom % 3 == 0) begin
				en_model = INT_SRC_N'($urandom);
				bus_xfer(OP_WR, INT_BASE + PI1_ADDR_W'(1), PI1_DATA_W'(en_model), 4'hf, got);
				read_check(INT_BASE + PI1_ADDR_W'(1), PI1_DATA_W'(en_model), "enable mask");
			end
			exp_idx = first_pending(pend_model & en_model);
			read_check(INT_BASE, exp_idx, "interrupt index");
			if (exp_idx != INT_NONE) begin
				k = int'(exp_idx);
				bus_xfer(OP_WR, INT_BASE, exp_idx, 4'hf, got);
				pend_model[k] = 1'b0;
				@(negedge clk_w);
				compare_ack(int_ack, INT_SRC_N'(1 << k));
				compare_bit("irq_o", irq, |(pend_model & en_model));
				@(negedge clk_w);
				compare_ack(int_ack, '0);
			end
		end

		// warm reset clears the enable mask but keeps the RAM
		bus_xfer(OP_WR, INT_BASE + PI1_ADDR_W'(1), PI1_DATA_W'(4'hf), 4'hf, got);
		bus_xfer(OP_WR, DEV_BASE + PI1_ADDR_W'(DEVTBL_RST_IDX), 32'h2, 4'hf, got);
		@(negedge clk_w);
		compare_bit("sys_rst_o", sys_rst, 1'b0);
		check_hold();
		read_check(INT_BASE + PI1_ADDR_W'(1), '0, "enable mask");
		check_ram_words(8);

		bus_xfer(OP_WR, DEV_BASE + PI1_ADDR_W'(DEVTBL_RST_IDX), 32'h1, 4'hf, got);
		@(negedge clk_w);
		compare_bit("sys_rst_o", sys_rst, 1'b0);
		repeat (3 * RST_CYCLES) begin
			@(negedge clk_w);
			compare_bit("sys_rst_o", sys_rst, 1'b1); // power-off holds until rst_p
		end
		@(posedge clk_w);
		#1;
		rst_p = 1'b1;
		repeat (2) @(posedge clk_w);
		#1;
		rst_p = 1'b0;
		check_hold();
		read_check(DEV_BASE + PI1_ADDR_W'(DEVTBL_RST_IDX), '0, "reset command");

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: soc_top.sv
/* one PI1 master port; sys_rst_o is the internal reset of the router and
   every slave, so it also covers software reset and power-off */
`timescale 1ns/1ps

module soc_top (
	input  logic                          clk_w,
	input  logic                          rst_p,
	input  pi1_pkg::pi1_req_t             req_i,
	output pi1_pkg::pi1_rsp_t             rsp_o,
	input  logic [pi1_pkg::INT_SRC_N-1:0] int_src_i,
	output logic                          irq_o,
	output logic [pi1_pkg::INT_SRC_N-1:0] int_ack_o,
	output logic                          sys_rst_o
);
	import pi1_pkg::*;

	pi1_req_t [SLV_N-1:0] s_req;
	pi1_rsp_t [SLV_N-1:0] s_rsp;
	logic [1:0]           swrst;

	rst_ctrl i_rst_ctrl (
		.clk_w     (clk_w),
		.rst_p     (rst_p),
		.swrst_i   (swrst),
		.sys_rst_o (sys_rst_o)
	);

	pi1_router i_router (
		.clk_w   (clk_w),
		.rst_p   (sys_rst_o),
		.m_req_i (req_i),
		.m_rsp_o (rsp_o),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp)
	);

	// #################### slaves
	scratch_ram i_ram (
		.clk_w (clk_w),
		.rst_p (sys_rst_o),
		.req_i (s_req[SLV_RAM]),
		.rsp_o (s_rsp[SLV_RAM])
	);

	devtbl i_devtbl (
		.clk_w   (clk_w),
		.rst_p   (sys_rst_o),
		.req_i   (s_req[SLV_DEV]),
		.rsp_o   (s_rsp[SLV_DEV]),
		.swrst_o (swrst)
	);

	intctrl i_intctrl (
		.clk_w     (clk_w),
		.rst_p     (sys_rst_o),
		.req_i     (s_req[SLV_INT]),
		.rsp_o     (s_rsp[SLV_INT]),
		.int_src_i (int_src_i),
		.irq_o     (irq_o),
		.int_ack_o (int_ack_o)
	);

endmodule

// File: intctrl.sv
/* sources are level inputs and pend on a rising edge; word 0 reads the
   lowest enabled pending index and takes an acknowledge, word 1 is the mask */
`timescale 1ns/1ps

module intctrl (
	input  logic                              clk_w,
	input  logic                              rst_p,
	input  pi1_pkg::pi1_req_t                 req_i,
	output pi1_pkg::pi1_rsp_t                 rsp_o,
	input  logic [pi1_pkg::INT_SRC_N-1:0]     int_src_i,
	output logic                              irq_o,
	output logic [pi1_pkg::INT_SRC_N-1:0]     int_ack_o
);
	import pi1_pkg::*;

	localparam int IDX_W = $clog2(INT_SRC_N);

	logic [INT_SRC_N-1:0]  src_q;
	logic [INT_SRC_N-1:0]  pend_q;
	logic [INT_SRC_N-1:0]  en_q;
	logic [INT_SRC_N-1:0]  ack_q;
	logic [INT_SRC_N-1:0]  act;
	logic [INT_SRC_N-1:0]  clr;
	logic [IDX_W-1:0]      best;
	logic [PI1_ADDR_W-1:0] off;
	logic [PI1_DATA_W-1:0] rd_val;
	logic [PI1_DATA_W-1:0] rd_q;
	logic                  rdy_q;
	logic                  wr_en;

	assign off   = req_i.addr - SLV_BASE[SLV_INT];
	assign act   = pend_q & en_q;
	assign wr_en = rdy_q && req_i.sel[0] && ((req_i.op == OP_WR) || (req_i.op == OP_RW));

	always_comb begin
		best = '0;
		for (int i = INT_SRC_N - 1; i >= 0; i--) begin
			if (act[i])
				best = IDX_W'(i); // lowest index wins
		end
	end

	always_comb begin
		clr = '0;
		if (wr_en && (off == '0) && (req_i.data < PI1_DATA_W'(INT_SRC_N)))
			clr[req_i.data[IDX_W-1:0]] = 1'b1;
	end

	always_comb begin
		case (off)
			PI1_ADDR_W'(0): rd_val = (act != '0) ? PI1_DATA_W'(best) : INT_NONE;
			PI1_ADDR_W'(1): rd_val = PI1_DATA_W'(en_q);
			default:        rd_val = '0;
		endcase
	end

	// ####################
	always_ff @(posedge clk_w) begin
		src_q <= int_src_i;
		if (rst_p) begin
			rdy_q  <= 1'b0;
			pend_q <= '0;
			en_q   <= '0;
			ack_q  <= '0;
		end else begin
			rdy_q  <= (req_i.op != OP_NOP) && !rdy_q;
			pend_q <= (pend_q & ~clr) | (int_src_i & ~src_q); // a new edge outranks a clear
			ack_q  <= clr;
			if (wr_en && (off == PI1_ADDR_W'(1)))
				en_q <= req_i.data[INT_SRC_N-1:0];
		end
	end

	always_ff @(posedge clk_w) begin
		if (!rdy_q)
			rd_q <= rd_val;
	end

	assign rsp_o.data = rd_q;
	assign rsp_o.rdy  = rdy_q;
	assign irq_o      = |act;
	assign int_ack_o  = ack_q;

endmodule

// File: devtbl.sv
/* sizes are reported in bytes; only byte 0 of a command write counts and
   swrst_o pulses for the one cycle after the completing edge */
`timescale 1ns/1ps

module devtbl (
	input  logic              clk_w,
	input  logic              rst_p,
	input  pi1_pkg::pi1_req_t req_i,
	output pi1_pkg::pi1_rsp_t rsp_o,
	output logic [1:0]        swrst_o
);
	import pi1_pkg::*;

	logic [PI1_ADDR_W-1:0] off;
	logic [PI1_DATA_W-1:0] rd_val;
	logic [PI1_DATA_W-1:0] rd_q;
	logic [1:0]            cmd_q;
	logic [1:0]            swrst_q;
	logic                  rdy_q;
	logic                  cmd_wr;

	assign off    = req_i.addr - SLV_BASE[SLV_DEV];
	assign cmd_wr = rdy_q && req_i.sel[0] && (off == PI1_ADDR_W'(DEVTBL_RST_IDX)) &&
		((req_i.op == OP_WR) || (req_i.op == OP_RW));

	always_comb begin
		rd_val = '0;
		for (int i = 0; i < SLV_N; i++) begin
			if (off == PI1_ADDR_W'(i))
				rd_val = PI1_DATA_W'(SLV_SIZE[i]) << 2; // words to bytes
		end
		if (off == PI1_ADDR_W'(DEVTBL_RST_IDX))
			rd_val = PI1_DATA_W'(cmd_q);
	end

	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			rdy_q   <= 1'b0;
			cmd_q   <= 2'b00;
			swrst_q <= 2'b00;
		end else begin
			rdy_q   <= (req_i.op != OP_NOP) && !rdy_q;
			swrst_q <= 2'b00;
			if (cmd_wr) begin
				cmd_q   <= req_i.data[1:0];
				swrst_q <= req_i.data[1:0];
			end
		end
	end

	always_ff @(posedge clk_w) begin
		if (!rdy_q)
			rd_q <= rd_val;
	end

	assign rsp_o.data = rd_q;
	assign rsp_o.rdy  = rdy_q;
	assign swrst_o    = swrst_q;

endmodule

// File: scratch_ram.sv
/* contents are not cleared by reset; the old word is read on the first
   request cycle and writes land on the completing edge */
`timescale 1ns/1ps

module scratch_ram (
	input  logic              clk_w,
	input  logic              rst_p,
	input  pi1_pkg::pi1_req_t req_i,
	output pi1_pkg::pi1_rsp_t rsp_o
);
	import pi1_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);

	logic [PI1_DATA_W-1:0] mem [RAM_WORDS];
	logic [PI1_DATA_W-1:0] rd_q;
	logic [PI1_DATA_W-1:0] wr_mask;
	logic [PI1_ADDR_W-1:0] off;
	logic [IDX_W-1:0]      idx;
	logic                  rdy_q;
	logic                  wr_en;

	assign off   = req_i.addr - SLV_BASE[SLV_RAM];
	assign idx   = off[IDX_W-1:0];
	assign wr_en = rdy_q && ((req_i.op == OP_WR) || (req_i.op == OP_RW));

	always_comb begin
		for (int b = 0; b < PI1_SEL_W; b++)
			wr_mask[b*8 +: 8] = {8{req_i.sel[b]}};
	end

	always_ff @(posedge clk_w) begin
		if (rst_p)
			rdy_q <= 1'b0;
		else
			rdy_q <= (req_i.op != OP_NOP) && !rdy_q;
	end

	always_ff @(posedge clk_w) begin
		if (!rdy_q)
			rd_q <= mem[idx]; // old word for RD and RW
		if (wr_en)
			mem[idx] <= (mem[idx] & ~wr_mask) | (req_i.data & wr_mask);
	end

	assign rsp_o.data = rd_q;
	assign rsp_o.rdy  = rdy_q;

endmodule

// File: pi1_router.sv
/* single master, no arbitration; a request outside every mapped region goes
   to the built-in default slave, which answers at once with zero */
`timescale 1ns/1ps

module pi1_router (
	input  logic                                   clk_w,
	input  logic                                   rst_p,
	input  pi1_pkg::pi1_req_t                      m_req_i,
	output pi1_pkg::pi1_rsp_t                      m_rsp_o,
	output pi1_pkg::pi1_req_t [pi1_pkg::SLV_N-1:0] s_req_o,
	input  pi1_pkg::pi1_rsp_t [pi1_pkg::SLV_N-1:0] s_rsp_i
);
	import pi1_pkg::*;

	localparam int IDX_W = $clog2(SLV_N);

	logic [SLV_N-1:0] hit;
	logic [IDX_W-1:0] cur_idx;
	logic             cur_vld;
	logic             dflt_sel;

	// #################### address decode
	always_comb begin
		hit = '0;
		for (int i = 0; i < SLV_N; i++) begin
			hit[i] = (m_req_i.addr >= SLV_BASE[i]) &&
				(m_req_i.addr < SLV_BASE[i] + SLV_SIZE[i]);
		end
	end

	always_comb begin
		cur_idx = '0;
		for (int i = SLV_N - 1; i >= 0; i--) begin
			if (hit[i])
				cur_idx = IDX_W'(i);
		end
	end

	assign cur_vld  = |hit;
	assign dflt_sel = (m_req_i.op != OP_NOP) && !cur_vld;

	always_comb begin
		for (int i = 0; i < SLV_N; i++) begin
			s_req_o[i] = m_req_i;
			if (!hit[i])
				s_req_o[i].op = OP_NOP; // only the addressed slave sees the request
		end
	end

	// #################### response path
	always_comb begin
		m_rsp_o = '0;
		if (dflt_sel)
			m_rsp_o.rdy = 1'b1; // default slave drops writes and reads zero
		else if (cur_vld)
			m_rsp_o = s_rsp_i[cur_idx];
	end

endmodule

// File: rst_ctrl.sv
/* swrst_i is {rst1, rst0} as a one-cycle pulse; rst1 restarts the hold count
   and rst0 alone latches power-off until the external reset */
`timescale 1ns/1ps

module rst_ctrl (
	input  logic       clk_w,
	input  logic       rst_p,
	input  logic [1:0] swrst_i,
	output logic       sys_rst_o
);
	import pi1_pkg::*;

	localparam int CNT_W = $clog2(RST_CYCLES + 1);

	logic [CNT_W-1:0] cnt_q;
	logic             pwroff_q;
	logic             reload;
	logic             pwroff_cmd;

	assign reload     = swrst_i[1];        // warm or cold reset
	assign pwroff_cmd = (swrst_i == 2'b01);

	always_ff @(posedge clk_w) begin
		if (rst_p) begin
			cnt_q    <= CNT_W'(RST_CYCLES);
			pwroff_q <= 1'b0;
		end else begin
			if (reload)
				cnt_q <= CNT_W'(RST_CYCLES);
			else if (cnt_q != '0)
				cnt_q <= cnt_q - 1'b1;
			if (pwroff_cmd)
				pwroff_q <= 1'b1; // held until rst_p
		end
	end

	assign sys_rst_o = rst_p || pwroff_q || (cnt_q != '0);

endmodule

// File: pi1_pkg.sv
/* PI1 bus types, operation codes and the word-addressed memory map
   shared by the router and all slaves */
package pi1_pkg;

	localparam int PI1_DATA_W = 32;
	localparam int PI1_ADDR_W = 30; // word address
	localparam int PI1_SEL_W  = 4;

	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_WR  = 2'd1,
		OP_RD  = 2'd2,
		OP_RW  = 2'd3 // returns the old word and writes the selected bytes
	} pi1_op_t;

	typedef struct packed {
		pi1_op_t               op;
		logic [PI1_ADDR_W-1:0] addr;
		logic [PI1_DATA_W-1:0] data;
		logic [PI1_SEL_W-1:0]  sel;
	} pi1_req_t;

	typedef struct packed {
		logic [PI1_DATA_W-1:0] data;
		logic                  rdy;
	} pi1_rsp_t;

	// ####################
	localparam int SLV_N     = 3;
	localparam int SLV_RAM   = 0;
	localparam int SLV_DEV   = 1;
	localparam int SLV_INT   = 2;
	localparam int RAM_WORDS = 1024;

	localparam logic [SLV_N-1:0][PI1_ADDR_W-1:0] SLV_BASE = {
		PI1_ADDR_W'(1088), PI1_ADDR_W'(1024), PI1_ADDR_W'(0)};
	localparam logic [SLV_N-1:0][PI1_ADDR_W-1:0] SLV_SIZE = {
		PI1_ADDR_W'(64), PI1_ADDR_W'(64), PI1_ADDR_W'(RAM_WORDS)};

	localparam int INT_SRC_N                  = 4;
	localparam logic [PI1_DATA_W-1:0] INT_NONE = '1;
	localparam int RST_CYCLES                 = 16;
	localparam int DEVTBL_RST_IDX             = 8; // reset command register

endpackage
